// ==== src/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int inst_w      = 32;
  localparam int addr_w      = 32;
  localparam int id_w        = 6;
  localparam int queue_depth = 8;
  localparam int qptr_w      = $clog2(queue_depth);
  localparam int free_w      = 4;                // holds 0 to queue_depth.
  localparam int reg_idx_w   = 5;
  localparam int op_w        = 6;

  //////////////////////////////////////////////////
  // instruction fields

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;

  localparam logic [1:0] grp_reg_alu = 2'b00;    // top two opcode bits.
  localparam logic [1:0] grp_imm_alu = 2'b01;
  localparam logic [1:0] grp_memory  = 2'b10;
  localparam logic [1:0] grp_branch  = 2'b11;

  // bit positions in the register-use mask
  localparam int reg_mask_w = 3;
  localparam int mask_rs0   = 0;
  localparam int mask_rs1   = 1;
  localparam int mask_rd    = 2;

  typedef logic [inst_w-1:0]     inst_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [id_w-1:0]       inst_id_t;
  typedef logic [reg_idx_w-1:0]  reg_idx_t;
  typedef logic [reg_mask_w-1:0] reg_mask_t;

  typedef enum logic [op_w-1:0] {
    op_nop   = 6'b000000,
    op_add   = 6'b000001,
    op_sub   = 6'b000010,
    op_cmp   = 6'b000110,
    op_test  = 6'b000111,
    op_jr    = 6'b001111,
    op_addi  = 6'b010001,
    op_cmpi  = 6'b010110,
    op_testi = 6'b010111,
    op_lw    = 6'b100000,
    op_sw    = 6'b100001,
    op_jmp   = 6'b110000,
    op_je    = 6'b110001
  } opcode_e;

  typedef enum logic [1:0] {
    pipe_none   = 2'd0,
    pipe_branch = 2'd1,
    pipe_memory = 2'd2
  } pipe_class_e;

endpackage

`default_nettype wire

// ==== src/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush,
  input  logic                        push0,
  input  logic                        push1,
  input  logic                        pop0,
  input  logic                        pop1,
  input  issue_pkg::inst_t            instruction0_in,
  input  issue_pkg::inst_t            instruction1_in,
  input  issue_pkg::addr_t            pc0_in,
  input  issue_pkg::addr_t            pc1_in,
  input  issue_pkg::inst_id_t         id0_in,
  input  issue_pkg::inst_id_t         id1_in,
  output logic                        slot0_valid,
  output logic                        slot1_valid,
  output logic                        stall,
  output issue_pkg::inst_t            slot0_inst,
  output issue_pkg::inst_t            slot1_inst,
  output issue_pkg::addr_t            slot0_pc,
  output issue_pkg::addr_t            slot1_pc,
  output issue_pkg::inst_id_t         slot0_id,
  output issue_pkg::inst_id_t         slot1_id,
  output logic [issue_pkg::free_w-1:0] free
);

  import issue_pkg::*;

  inst_t    inst_mem [queue_depth];
  addr_t    pc_mem   [queue_depth];
  inst_id_t id_mem   [queue_depth];

  logic [qptr_w-1:0] rd_ptr;
  logic [qptr_w-1:0] rd_ptr1;
  logic [qptr_w-1:0] wr_ptr;
  logic [qptr_w-1:0] wr_ptr1;
  logic [free_w-1:0] count;
  logic [1:0]        push_n;
  logic [1:0]        pop_n;

  assign push_n  = {1'b0, push0} + {1'b0, push1};
  assign pop_n   = {1'b0, pop0} + {1'b0, pop1};
  assign rd_ptr1 = rd_ptr + 1'b1;                // wraps, depth is a power of two.
  assign wr_ptr1 = wr_ptr + 1'b1;

  //////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (push0) begin
      inst_mem[wr_ptr] <= instruction0_in;
      pc_mem[wr_ptr]   <= pc0_in;
      id_mem[wr_ptr]   <= id0_in;
    end
    if (push1) begin
      inst_mem[wr_ptr1] <= instruction1_in;
      pc_mem[wr_ptr1]   <= pc1_in;
      id_mem[wr_ptr1]   <= id1_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr + qptr_w'(pop_n);
      wr_ptr <= wr_ptr + qptr_w'(push_n);
      count  <= count + free_w'(push_n) - free_w'(pop_n); // push and pop combine.
    end
  end

  //////////////////////////////////////////////////
  // head slots, zero when empty

  assign slot0_valid = count != '0;
  assign slot1_valid = count > free_w'(1);

  assign slot0_inst = slot0_valid ? inst_mem[rd_ptr]  : '0; // reads as op_nop.
  assign slot0_pc   = slot0_valid ? pc_mem[rd_ptr]    : '0;
  assign slot0_id   = slot0_valid ? id_mem[rd_ptr]    : '0;
  assign slot1_inst = slot1_valid ? inst_mem[rd_ptr1] : '0;
  assign slot1_pc   = slot1_valid ? pc_mem[rd_ptr1]   : '0;
  assign slot1_id   = slot1_valid ? id_mem[rd_ptr1]   : '0;

  assign free  = free_w'(queue_depth) - count;
  assign stall = free < free_w'(2);              // room for a full pair.

  a_pop_occupancy: assert property (@(posedge clk) disable iff (!rst_n || flush)
    free_w'(pop_n) <= count)
    else $error("issue_queue pop beyond occupancy");

  a_push1_alone: assert property (@(posedge clk) disable iff (!rst_n || flush)
    push1 |-> push0)
    else $error("issue_queue push1 without push0");

  a_overflow: assert property (@(posedge clk) disable iff (!rst_n || flush)
    free_w'(push_n) <= free)
    else $error("issue_queue overflow");

endmodule

`default_nettype wire

// ==== src/reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_decode (
  input  issue_pkg::inst_t       inst,
  output issue_pkg::reg_idx_t    src0,
  output issue_pkg::reg_idx_t    src1,
  output issue_pkg::reg_idx_t    dest,
  output issue_pkg::reg_mask_t   use_mask,
  output issue_pkg::pipe_class_e pipe_class
);

  import issue_pkg::*;

  opcode_e    op;
  logic [1:0] grp;
  reg_idx_t   rs;
  reg_idx_t   rt;
  reg_idx_t   rd;

  assign op  = opcode_e'(inst[opcode_msb:opcode_lsb]);
  assign grp = inst[opcode_msb:opcode_msb-1];
  assign rs  = inst[rs_msb:rs_lsb];
  assign rt  = inst[rt_msb:rt_lsb];
  assign rd  = inst[rd_msb:rd_lsb];

  always_comb begin
    src0     = '0;
    src1     = '0;
    dest     = '0;
    use_mask = '0;
    case (grp)
      grp_reg_alu: begin
        if (op == op_jr) begin
          src0               = rs;
          use_mask[mask_rs0] = 1'b1;
        end else if (op != op_nop) begin
          src0     = rs;
          src1     = rt;
          dest     = rd;
          use_mask = '1;                         // rs, rt and rd.
        end
      end
      grp_imm_alu: begin
        src0               = rs;
        dest               = rt;
        use_mask[mask_rs0] = 1'b1;
        use_mask[mask_rd]  = 1'b1;
      end
      grp_memory: begin
        src0               = rs;
        use_mask[mask_rs0] = op == op_lw || op == op_sw;
        if (op == op_lw) begin
          dest              = rt;
          use_mask[mask_rd] = 1'b1;
        end else if (op == op_sw) begin
          src1               = rt;
          use_mask[mask_rs1] = 1'b1;
        end
      end
      default: use_mask = '0;                    // branches.
    endcase
  end

  always_comb begin
    if (grp == grp_memory) begin
      pipe_class = pipe_memory;
    end else if (grp == grp_branch || op == op_cmp || op == op_test ||
                 op == op_cmpi || op == op_testi) begin
      pipe_class = pipe_branch;
    end else begin
      pipe_class = pipe_none;
    end
  end

endmodule

`default_nettype wire

// ==== src/hazard_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_check (
  input  logic                 slot0_valid,
  input  logic                 slot1_valid,
  input  logic                 load_pending,
  input  issue_pkg::reg_idx_t  load_dest,
  input  issue_pkg::reg_idx_t  src0_0,
  input  issue_pkg::reg_idx_t  src1_0,
  input  issue_pkg::reg_idx_t  dest_0,
  input  issue_pkg::reg_idx_t  src0_1,
  input  issue_pkg::reg_idx_t  src1_1,
  input  issue_pkg::reg_mask_t use_mask_0,
  input  issue_pkg::reg_mask_t use_mask_1,
  output logic [1:0]           issue_mask
);

  import issue_pkg::*;

  logic load_hit;
  logic split_hit;

  // true when a source the slot actually reads equals r.
  function automatic logic reads_reg(
    input reg_mask_t mask,
    input reg_idx_t  s0,
    input reg_idx_t  s1,
    input reg_idx_t  r
  );
    return (mask[mask_rs0] && s0 == r) || (mask[mask_rs1] && s1 == r);
  endfunction

  assign load_hit = load_pending &&
                    (reads_reg(use_mask_0, src0_0, src1_0, load_dest) ||
                     reads_reg(use_mask_1, src0_1, src1_1, load_dest));

  assign split_hit = use_mask_0[mask_rd] &&
                     reads_reg(use_mask_1, src0_1, src1_1, dest_0);

  always_comb begin
    if (load_hit) begin
      issue_mask = 2'b00;                        // wait for the load.
    end else if (split_hit) begin
      issue_mask = {1'b0, slot0_valid};          // slot 1 goes next cycle.
    end else begin
      issue_mask = {slot1_valid, slot0_valid};
    end
  end

endmodule

`default_nettype wire

// ==== src/pipe_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_steer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic [1:0]             issue_mask,
  input  issue_pkg::pipe_class_e class0,
  input  issue_pkg::pipe_class_e class1,
  input  issue_pkg::inst_t       slot0_inst,
  input  issue_pkg::inst_t       slot1_inst,
  input  issue_pkg::addr_t       slot0_pc,
  input  issue_pkg::addr_t       slot1_pc,
  input  issue_pkg::inst_id_t    slot0_id,
  input  issue_pkg::inst_id_t    slot1_id,
  output logic                   pop0,
  output logic                   pop1,
  output issue_pkg::inst_t       lane0_inst,
  output issue_pkg::inst_t       lane1_inst,
  output issue_pkg::addr_t       lane0_pc,
  output issue_pkg::addr_t       lane1_pc,
  output issue_pkg::inst_id_t    lane0_id,
  output issue_pkg::inst_id_t    lane1_id
);

  import issue_pkg::*;

  logic [1:0] steer_mask;
  logic [1:0] fin_mask;
  logic       swap;
  logic       lane0_vld;
  logic       lane1_vld;
  inst_t      lane0_inst_nxt;
  inst_t      lane1_inst_nxt;
  addr_t      lane0_pc_nxt;
  addr_t      lane1_pc_nxt;
  inst_id_t   lane0_id_nxt;
  inst_id_t   lane1_id_nxt;

  //////////////////////////////////////////////////
  // lane pairing

  always_comb begin
    steer_mask = 2'b11;
    swap       = 1'b0;
    case ({class0, class1})
      {pipe_branch, pipe_branch}: steer_mask = 2'b01; // one branch lane.
      {pipe_memory, pipe_memory}: begin
        steer_mask = 2'b01;
        swap       = 1'b1;
      end
      {pipe_memory, pipe_branch},
      {pipe_memory, pipe_none},
      {pipe_none,   pipe_branch}: swap = 1'b1;
      default: steer_mask = 2'b11;
    endcase
  end

  assign fin_mask = issue_mask & steer_mask;
  assign pop0     = fin_mask[0];
  assign pop1     = fin_mask[1];

  //////////////////////////////////////////////////
  // lane registers

  assign lane0_vld = swap ? fin_mask[1] : fin_mask[0];
  assign lane1_vld = swap ? fin_mask[0] : fin_mask[1];

  assign lane0_inst_nxt = !lane0_vld ? '0 : swap ? slot1_inst : slot0_inst;
  assign lane0_pc_nxt   = !lane0_vld ? '0 : swap ? slot1_pc   : slot0_pc;
  assign lane0_id_nxt   = !lane0_vld ? '0 : swap ? slot1_id   : slot0_id;
  assign lane1_inst_nxt = !lane1_vld ? '0 : swap ? slot0_inst : slot1_inst;
  assign lane1_pc_nxt   = !lane1_vld ? '0 : swap ? slot0_pc   : slot1_pc;
  assign lane1_id_nxt   = !lane1_vld ? '0 : swap ? slot0_id   : slot1_id;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      lane0_inst <= '0;
      lane0_pc   <= '0;
      lane0_id   <= '0;
      lane1_inst <= '0;
      lane1_pc   <= '0;
      lane1_id   <= '0;
    end else begin
      lane0_inst <= lane0_inst_nxt;
      lane0_pc   <= lane0_pc_nxt;
      lane0_id   <= lane0_id_nxt;
      lane1_inst <= lane1_inst_nxt;
      lane1_pc   <= lane1_pc_nxt;
      lane1_id   <= lane1_id_nxt;
    end
  end

  // queue must retire in order across hazard and pairing.
  a_pop_order: assert property (@(posedge clk) disable iff (!rst_n)
    pop1 |-> pop0)
    else $error("pipe_steer pop1 without pop0");

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush,
  input  logic                         push0,
  input  logic                         push1,
  input  issue_pkg::inst_t             instruction0_in,
  input  issue_pkg::inst_t             instruction1_in,
  input  issue_pkg::addr_t             pc0_in,
  input  issue_pkg::addr_t             pc1_in,
  input  issue_pkg::inst_id_t          id0_in,
  input  issue_pkg::inst_id_t          id1_in,
  input  logic                         load_pending,
  input  issue_pkg::reg_idx_t          load_dest,
  output logic                         stall,
  output logic [issue_pkg::free_w-1:0] free,
  output issue_pkg::inst_t             lane0_inst,
  output issue_pkg::inst_t             lane1_inst,
  output issue_pkg::addr_t             lane0_pc,
  output issue_pkg::addr_t             lane1_pc,
  output issue_pkg::inst_id_t          lane0_id,
  output issue_pkg::inst_id_t          lane1_id
);

  import issue_pkg::*;

  logic        slot0_valid, slot1_valid;
  logic        pop0, pop1;
  inst_t       slot0_inst, slot1_inst;
  addr_t       slot0_pc, slot1_pc;
  inst_id_t    slot0_id, slot1_id;
  reg_idx_t    src0_0, src1_0, dest_0;
  reg_idx_t    src0_1, src1_1;
  reg_mask_t   use_mask_0, use_mask_1;
  pipe_class_e class0, class1;
  logic [1:0]  issue_mask;

  issue_queue q0 (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .push0(push0), .push1(push1), .pop0(pop0), .pop1(pop1),
    .instruction0_in(instruction0_in), .instruction1_in(instruction1_in),
    .pc0_in(pc0_in), .pc1_in(pc1_in), .id0_in(id0_in), .id1_in(id1_in),
    .slot0_valid(slot0_valid), .slot1_valid(slot1_valid), .stall(stall),
    .slot0_inst(slot0_inst), .slot1_inst(slot1_inst),
    .slot0_pc(slot0_pc), .slot1_pc(slot1_pc),
    .slot0_id(slot0_id), .slot1_id(slot1_id), .free(free)
  );

  reg_decode dec0 (
    .inst(slot0_inst), .src0(src0_0), .src1(src1_0), .dest(dest_0),
    .use_mask(use_mask_0), .pipe_class(class0)
  );

  reg_decode dec1 (
    .inst(slot1_inst), .src0(src0_1), .src1(src1_1),
    .dest(),                                     // only slot 0 can hazard a later slot.
    .use_mask(use_mask_1), .pipe_class(class1)
  );

  hazard_check hz0 (
    .slot0_valid(slot0_valid), .slot1_valid(slot1_valid),
    .load_pending(load_pending), .load_dest(load_dest),
    .src0_0(src0_0), .src1_0(src1_0), .dest_0(dest_0),
    .src0_1(src0_1), .src1_1(src1_1),
    .use_mask_0(use_mask_0), .use_mask_1(use_mask_1),
    .issue_mask(issue_mask)
  );

  pipe_steer st0 (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .issue_mask(issue_mask), .class0(class0), .class1(class1),
    .slot0_inst(slot0_inst), .slot1_inst(slot1_inst),
    .slot0_pc(slot0_pc), .slot1_pc(slot1_pc),
    .slot0_id(slot0_id), .slot1_id(slot1_id),
    .pop0(pop0), .pop1(pop1),
    .lane0_inst(lane0_inst), .lane1_inst(lane1_inst),
    .lane0_pc(lane0_pc), .lane1_pc(lane1_pc),
    .lane0_id(lane0_id), .lane1_id(lane1_id)
  );

endmodule

`default_nettype wire

// ==== sim/tb_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

  import issue_pkg::*;

  localparam int max_cycles = 400;               // roughly three times a normal run.

  typedef struct packed {
    inst_t    inst;
    addr_t    pc;
    inst_id_t id;
  } entry_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              flush;
  logic              push0;
  logic              push1;
  inst_t             instruction0_in;
  inst_t             instruction1_in;
  addr_t             pc0_in;
  addr_t             pc1_in;
  inst_id_t          id0_in;
  inst_id_t          id1_in;
  logic              load_pending;
  reg_idx_t          load_dest;
  logic              stall;
  logic [free_w-1:0] free;
  inst_t             lane0_inst;
  inst_t             lane1_inst;
  addr_t             lane0_pc;
  addr_t             lane1_pc;
  inst_id_t          lane0_id;
  inst_id_t          lane1_id;

  entry_t            ref_q [$];                  // oldest entry at index 0.
  inst_t             exp_lane0_inst = '0;
  inst_t             exp_lane1_inst = '0;
  addr_t             exp_lane0_pc   = '0;
  addr_t             exp_lane1_pc   = '0;
  inst_id_t          exp_lane0_id   = '0;
  inst_id_t          exp_lane1_id   = '0;
  logic [free_w-1:0] exp_free       = free_w'(queue_depth);
  logic              exp_stall      = 1'b0;
  int                cycles         = 0;
  opcode_e           op_list [13]   = '{op_nop, op_add, op_sub, op_cmp, op_test, op_jr,
                                        op_addi, op_cmpi, op_testi, op_lw, op_sw,
                                        op_jmp, op_je};

  issue_stage dut0 (
    .clk(clk), .rst_n(rst_n), .flush(flush), .push0(push0), .push1(push1),
    .instruction0_in(instruction0_in), .instruction1_in(instruction1_in),
    .pc0_in(pc0_in), .pc1_in(pc1_in), .id0_in(id0_in), .id1_in(id1_in),
    .load_pending(load_pending), .load_dest(load_dest), .stall(stall), .free(free),
    .lane0_inst(lane0_inst), .lane1_inst(lane1_inst), .lane0_pc(lane0_pc),
    .lane1_pc(lane1_pc), .lane0_id(lane0_id), .lane1_id(lane1_id)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // reference decode

  function automatic logic reads(input inst_t i, input reg_idx_t r);
    reg_idx_t rs;
    reg_idx_t rt;
    rs = i[rs_msb:rs_lsb];
    rt = i[rt_msb:rt_lsb];
    case (opcode_e'(i[opcode_msb:opcode_lsb]))
      op_add, op_sub, op_cmp, op_test, op_sw: return rs == r || rt == r;
      op_jr, op_addi, op_cmpi, op_testi, op_lw: return rs == r;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic writes(input inst_t i);
    case (opcode_e'(i[opcode_msb:opcode_lsb]))
      op_add, op_sub, op_cmp, op_test, op_addi, op_cmpi, op_testi, op_lw: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic reg_idx_t dest_of(input inst_t i);
    case (opcode_e'(i[opcode_msb:opcode_lsb]))
      op_add, op_sub, op_cmp, op_test: return i[rd_msb:rd_lsb];
      default: return i[rt_msb:rt_lsb];         // immediate ops and loads.
    endcase
  endfunction

  function automatic pipe_class_e class_of(input inst_t i);
    case (opcode_e'(i[opcode_msb:opcode_lsb]))
      op_lw, op_sw: return pipe_memory;
      op_cmp, op_test, op_cmpi, op_testi, op_jmp, op_je: return pipe_branch;
      default: return pipe_none;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // reference queue and lanes

  always @(posedge clk) begin : ref_model
    entry_t      s0;
    entry_t      s1;
    entry_t      l0;
    entry_t      l1;
    pipe_class_e c0;
    pipe_class_e c1;
    logic [1:0]  go;
    logic        swap;
    l0 = '0;
    l1 = '0;
    if (!rst_n || flush) begin
      ref_q.delete();
    end else begin
      s0 = ref_q.size() > 0 ? ref_q[0] : '0;
      s1 = ref_q.size() > 1 ? ref_q[1] : '0;
      go = {ref_q.size() > 1, ref_q.size() > 0};
      if (load_pending && (reads(s0.inst, load_dest) || reads(s1.inst, load_dest))) begin
        go = 2'b00;
      end else if (writes(s0.inst) && reads(s1.inst, dest_of(s0.inst))) begin
        go[1] = 1'b0;
      end
      c0 = class_of(s0.inst);
      c1 = class_of(s1.inst);
      if (c0 == c1 && c0 != pipe_none) begin
        go[1] = 1'b0;                            // only one lane of that kind.
      end
      swap = c0 == pipe_memory || (c0 == pipe_none && c1 == pipe_branch);
      if (go[0]) begin
        if (swap) l1 = s0;
        else l0 = s0;
        void'(ref_q.pop_front());
      end
      if (go[1]) begin
        if (swap) l0 = s1;
        else l1 = s1;
        void'(ref_q.pop_front());
      end
      if (push0) ref_q.push_back(entry_t'({instruction0_in, pc0_in, id0_in}));
      if (push1) ref_q.push_back(entry_t'({instruction1_in, pc1_in, id1_in}));
    end
    exp_lane0_inst <= l0.inst;
    exp_lane0_pc   <= l0.pc;
    exp_lane0_id   <= l0.id;
    exp_lane1_inst <= l1.inst;
    exp_lane1_pc   <= l1.pc;
    exp_lane1_id   <= l1.id;
    exp_free       <= free_w'(queue_depth - ref_q.size());
    exp_stall      <= (queue_depth - ref_q.size()) < 2;
  end

  //////////////////////////////////////////////////
  // checks

  task automatic report_failure(input string what);
    $display("mismatch at %0t ns: %s differs from the reference model", $time, what);
    $display("TEST FAILED");
    $fatal(1, "output check failed");
  endtask

  a_lane0_inst: assert property (@(posedge clk) disable iff (!rst_n)
    lane0_inst == exp_lane0_inst) else report_failure("lane0_inst");
  a_lane1_inst: assert property (@(posedge clk) disable iff (!rst_n)
    lane1_inst == exp_lane1_inst) else report_failure("lane1_inst");
  a_lane0_pc: assert property (@(posedge clk) disable iff (!rst_n)
    lane0_pc == exp_lane0_pc) else report_failure("lane0_pc");
  a_lane1_pc: assert property (@(posedge clk) disable iff (!rst_n)
    lane1_pc == exp_lane1_pc) else report_failure("lane1_pc");
  a_lane0_id: assert property (@(posedge clk) disable iff (!rst_n)
    lane0_id == exp_lane0_id) else report_failure("lane0_id");
  a_lane1_id: assert property (@(posedge clk) disable iff (!rst_n)
    lane1_id == exp_lane1_id) else report_failure("lane1_id");
  a_free: assert property (@(posedge clk) disable iff (!rst_n)
    free == exp_free) else report_failure("free");
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall == exp_stall) else report_failure("stall");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers

  function automatic inst_t r_format(input opcode_e op, input reg_idx_t rs,
                                     input reg_idx_t rt, input reg_idx_t rd);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic inst_t i_format(input opcode_e op, input reg_idx_t rs,
                                     input reg_idx_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic reg_idx_t pick_reg(input int unsigned lo, input int unsigned hi);
    return reg_idx_t'($urandom_range(hi, lo));
  endfunction

  function automatic inst_t rand_inst();
    return {op_list[$urandom_range(12, 0)], pick_reg(0, 7), pick_reg(0, 7),
            pick_reg(0, 7), 11'h000};         // small register range makes hazards.
  endfunction

  task automatic drive_push(input logic p0, input logic p1, input inst_t a, input inst_t b);
    push0           = p0;
    push1           = p1;
    instruction0_in = a;
    instruction1_in = b;
    pc0_in          = $urandom();
    pc1_in          = $urandom();
    id0_in          = inst_id_t'($urandom());
    id1_in          = inst_id_t'($urandom());
  endtask

  task automatic push_pair(input inst_t a, input inst_t b);
    @(negedge clk);
    while (stall) begin
      drive_push(1'b0, 1'b0, '0, '0);
      @(negedge clk);
    end
    drive_push(1'b1, 1'b1, a, b);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      drive_push(1'b0, 1'b0, '0, '0);
    end
  endtask

  task automatic drain_queue();
    idle_cycles(1);
    while (free != free_w'(queue_depth)) @(negedge clk);
  endtask

  task automatic push_and_drain(input inst_t a, input inst_t b);
    push_pair(a, b);
    drain_queue();
  endtask

  function automatic inst_t low_add();
    return r_format(op_add, pick_reg(1, 15), pick_reg(1, 15), pick_reg(1, 15));
  endfunction

  function automatic inst_t high_sub();
    return r_format(op_sub, pick_reg(16, 31), pick_reg(16, 31), pick_reg(16, 31));
  endfunction

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    void'($urandom(32'h24e64528));
    rst_n        = 1'b0;
    flush        = 1'b0;
    load_pending = 1'b0;
    load_dest    = '0;
    drive_push(1'b0, 1'b0, '0, '0);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    repeat (3) push_pair(low_add(), high_sub()); // independent pairs.
    drain_queue();

    push_and_drain(r_format(op_add, 5'd1, 5'd2, 5'd5), r_format(op_sub, 5'd5, 5'd3, 5'd6));
    push_and_drain(i_format(op_lw, 5'd4, 5'd8, 16'h0010), r_format(op_add, 5'd8, 5'd9, 5'd10));

    // load-use on slot 0, then on slot 1.
    load_pending = 1'b1;
    load_dest    = 5'd7;
    push_pair(r_format(op_add, 5'd7, 5'd1, 5'd2), r_format(op_sub, 5'd3, 5'd4, 5'd11));
    idle_cycles(4);
    load_pending = 1'b0;
    drain_queue();
    load_pending = 1'b1;
    push_pair(r_format(op_add, 5'd1, 5'd2, 5'd3), i_format(op_sw, 5'd12, 5'd7, 16'h0004));
    idle_cycles(3);
    load_pending = 1'b0;
    drain_queue();

    push_and_drain(i_format(op_lw, 5'd1, 5'd12, 16'h0010), i_format(op_sw, 5'd2, 5'd13, 16'h0020));
    push_and_drain(i_format(op_lw, 5'd3, 5'd14, 16'h0030), i_format(op_je, 5'd4, 5'd5, 16'h0040));
    push_and_drain(i_format(op_jmp, 5'd0, 5'd0, 16'h0100), i_format(op_je, 5'd6, 5'd7, 16'h0008));
    push_and_drain(r_format(op_add, 5'd8, 5'd9, 5'd17), r_format(op_cmp, 5'd18, 5'd19, 5'd20));
    push_and_drain(r_format(op_cmp, 5'd21, 5'd22, 5'd23), i_format(op_addi, 5'd24, 5'd25, 16'h0001));

    // fill while the head waits on a load.
    load_pending = 1'b1;
    load_dest    = 5'd9;
    push_pair(r_format(op_add, 5'd9, 5'd1, 5'd2), r_format(op_add, 5'd3, 5'd4, 5'd5));
    repeat (3) push_pair(high_sub(), high_sub());
    idle_cycles(2);
    load_pending = 1'b0;
    drain_queue();

    repeat (3) push_pair(low_add(), high_sub());
    @(negedge clk);
    flush = 1'b1;
    drive_push(1'b1, 1'b1, low_add(), high_sub()); // flush wins over the push.
    @(negedge clk);
    flush = 1'b0;
    drive_push(1'b0, 1'b0, '0, '0);
    push_and_drain(low_add(), high_sub());

    push_pair(low_add(), high_sub());
    push_pair(i_format(op_lw, 5'd1, 5'd2, 16'h0008), r_format(op_add, 5'd2, 5'd3, 5'd4));
    @(negedge clk);
    drive_push(1'b0, 1'b0, '0, '0);
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    push_and_drain(low_add(), high_sub());

    // mixed random stream.
    repeat (40) begin
      @(negedge clk);
      load_pending = $urandom_range(3, 0) == 0;
      load_dest    = pick_reg(0, 7);
      if (stall) drive_push(1'b0, 1'b0, '0, '0);
      else drive_push(1'b1, $urandom_range(1, 0) == 1, rand_inst(), rand_inst());
    end
    load_pending = 1'b0;
    drain_queue();
    idle_cycles(2);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== issue_stage.f ====
src/issue_pkg.sv
src/issue_queue.sv
src/reg_decode.sv
src/hazard_check.sv
src/pipe_steer.sv
src/issue_stage.sv
sim/tb_issue_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the issue stage testbench with Verilator and runs it.

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_issue_stage \
  -f issue_stage.f --Mdir "$build_dir" -o tb_issue_stage
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

"./$build_dir/tb_issue_stage" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
  echo "run_sim: failure reported in $log_file"
  exit 1
fi

echo "run_sim: simulation passed"
exit 0
